// ==== div_pkg.sv ====
// Integer divide unit definitions

package div_pkg;

	// ========================================
	// Widths and sizes
	// ========================================

	// Operand and result width
	localparam int DATA_W = 32;

	// Immediate divisor field, sign-extended to DATA_W
	localparam int IMM_W = 16;

	// Destination tag carried through to writeback
	localparam int TAG_W = 4;

	// Queue entries, equal to the credits upstream starts with
	localparam int OPQ_DEPTH = 4;
	localparam int OPQ_PTR_W = $clog2(OPQ_DEPTH);
	localparam int OPQ_CNT_W = $clog2(OPQ_DEPTH + 1);

	// Divider step counter, one step per quotient bit
	localparam int CNT_W = 6;
	localparam logic [CNT_W-1:0] STEP_LAST = CNT_W'(DATA_W - 1);

	// ========================================
	// Enumerations
	// ========================================

	// Signed forms first, each followed by its unsigned twin
	typedef enum logic [1:0] {
		DOP_DIV  = 2'd0,
		DOP_DIVU = 2'd1,
		DOP_REM  = 2'd2,
		DOP_REMU = 2'd3
	} div_op_e;

	typedef enum logic [1:0] {
		CAUSE_NONE = 2'd0,
		CAUSE_DBZ  = 2'd1
	} cause_e;

	typedef enum logic [1:0] {
		CS_IDLE = 2'd0,
		CS_RUN  = 2'd1,
		CS_DONE = 2'd2
	} core_state_e;

	// ========================================
	// Micro-op and result
	// ========================================

	typedef struct packed {
		logic             valid;
		div_op_e          op;
		logic             use_imm;
		logic [TAG_W-1:0] tag;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [IMM_W-1:0] imm;
	} div_uop_t;

	typedef struct packed {
		logic              valid;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] value;
		cause_e            cause;
	} div_result_t;

endpackage

// ==== div_core.sv ====
// Restoring divider core

`timescale 1ns/1ps

module div_core (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ld,
	input  logic                       sgn,
	input  logic [div_pkg::DATA_W-1:0] dividend,
	input  logic [div_pkg::DATA_W-1:0] divisor,
	output logic [div_pkg::DATA_W-1:0] quo,
	output logic [div_pkg::DATA_W-1:0] rem,
	output logic                       dbz,
	output logic                       done
);

	div_pkg::core_state_e state;
	logic [div_pkg::CNT_W-1:0] cnt;

	// Dividend shifts out of the top while quotient bits shift in at the bottom
	logic [div_pkg::DATA_W-1:0] q_reg;
	// Partial remainder
	logic [div_pkg::DATA_W-1:0] p_reg;
	// Divisor magnitude
	logic [div_pkg::DATA_W-1:0] d_reg;
	// Sign fix flags and zero divisor flag for the op in flight
	logic neg_q;
	logic neg_r;
	logic dbz_q;

	logic a_neg;
	logic b_neg;
	logic div_zero;
	logic [div_pkg::DATA_W-1:0] a_mag;
	logic [div_pkg::DATA_W-1:0] b_mag;
	logic [div_pkg::DATA_W:0] shifted;
	logic [div_pkg::DATA_W:0] diff;
	logic step_ok;

	// ========================================
	// Operand magnitudes
	// ========================================

	// Only signed ops treat the top bit as a sign
	assign a_neg = sgn & dividend[div_pkg::DATA_W-1];
	assign b_neg = sgn & divisor[div_pkg::DATA_W-1];
	assign a_mag = a_neg ? -dividend : dividend;
	assign b_mag = b_neg ? -divisor : divisor;
	assign div_zero = (divisor == '0);

	// One restoring step shifts in the next dividend bit and tries the subtract
	assign shifted = {p_reg, q_reg[div_pkg::DATA_W-1]};
	assign diff = shifted - {1'b0, d_reg};
	// A borrow out of the top bit means the divisor did not fit
	assign step_ok = ~diff[div_pkg::DATA_W];

	// ========================================
	// Control FSM
	// ========================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= div_pkg::CS_IDLE;
			cnt <= '0;
		end
		else
		begin
			case (state)
				div_pkg::CS_IDLE:
				begin
					cnt <= '0;
					// A zero divisor has its answer ready straight away
					if (ld)
						state <= div_zero ? div_pkg::CS_DONE : div_pkg::CS_RUN;
				end
				div_pkg::CS_RUN:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == div_pkg::STEP_LAST)
						state <= div_pkg::CS_DONE;
				end
				div_pkg::CS_DONE:
					state <= div_pkg::CS_IDLE;
				default:
					state <= div_pkg::CS_IDLE;
			endcase
		end
	end

	// ========================================
	// Data path
	// ========================================

	always_ff @(posedge clk)
	begin
		if (state == div_pkg::CS_IDLE && ld)
		begin
			d_reg <= b_mag;
			dbz_q <= div_zero;
			if (div_zero)
			begin
				// Quotient all ones and the dividend passed through untouched
				q_reg <= '1;
				p_reg <= dividend;
				neg_q <= 1'b0;
				neg_r <= 1'b0;
			end
			else
			begin
				q_reg <= a_mag;
				p_reg <= '0;
				neg_q <= a_neg ^ b_neg;
				neg_r <= a_neg;
			end
		end
		else if (state == div_pkg::CS_RUN)
		begin
			q_reg <= {q_reg[div_pkg::DATA_W-2:0], step_ok};
			p_reg <= step_ok ? diff[div_pkg::DATA_W-1:0] : shifted[div_pkg::DATA_W-1:0];
		end
	end

	// The quotient is negative on differing signs and the remainder follows the dividend
	// The most negative value over minus one wraps back to itself here
	assign quo = neg_q ? -q_reg : q_reg;
	assign rem = neg_r ? -p_reg : p_reg;
	assign dbz = dbz_q;
	assign done = (state == div_pkg::CS_DONE);

	// The unit holds off new loads until the current divide has finished
	ld_idle_a: assert property (@(posedge clk) disable iff (rst)
		ld |-> state == div_pkg::CS_IDLE);

	// A nonzero divisor answers DATA_W+1 cycles after the load and done then lasts one cycle
	done_pulse_a: assert property (@(posedge clk) disable iff (rst)
		ld && !div_zero |-> ##(div_pkg::DATA_W + 1) done ##1 !done);

endmodule

// ==== div_unit.sv ====
// Divide execution unit

`timescale 1ns/1ps

module div_unit (
	input  logic                 clk,
	input  logic                 rst,
	input  div_pkg::div_uop_t    uop,
	output logic                 busy,
	output div_pkg::div_result_t result
);

	logic sgn;
	logic [div_pkg::DATA_W-1:0] imm_ext;
	logic [div_pkg::DATA_W-1:0] divisor;
	logic [div_pkg::DATA_W-1:0] quo;
	logic [div_pkg::DATA_W-1:0] rem;
	logic dbz;
	logic done;

	// Tag and op of the micro-op in the divider
	logic [div_pkg::TAG_W-1:0] tag_q;
	div_pkg::div_op_e op_q;
	logic want_rem;
	div_pkg::div_result_t result_q;

	// ========================================
	// Decode and divisor select
	// ========================================

	// Signed forms interpret both operands as two's complement
	assign sgn = (uop.op == div_pkg::DOP_DIV) || (uop.op == div_pkg::DOP_REM);

	// The immediate is sign-extended regardless of the op's signedness
	assign imm_ext = {{(div_pkg::DATA_W - div_pkg::IMM_W){uop.imm[div_pkg::IMM_W-1]}}, uop.imm};
	assign divisor = uop.use_imm ? imm_ext : uop.b;

	// The queue only presents a micro-op while the unit is free, so it loads the core directly
	div_core div_core_inst (
		.clk      (clk),
		.rst      (rst),
		.ld       (uop.valid),
		.sgn      (sgn),
		.dividend (uop.a),
		.divisor  (divisor),
		.quo      (quo),
		.rem      (rem),
		.dbz      (dbz),
		.done     (done)
	);

	// Busy from the pop edge until the result goes out
	always_ff @(posedge clk)
	begin
		if (rst)
			busy <= 1'b0;
		else if (uop.valid)
			busy <= 1'b1;
		else if (done)
			busy <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (uop.valid)
		begin
			tag_q <= uop.tag;
			op_q <= uop.op;
		end
	end

	// ========================================
	// Result select and register
	// ========================================

	assign want_rem = (op_q == div_pkg::DOP_REM) || (op_q == div_pkg::DOP_REMU);

	always_ff @(posedge clk)
	begin
		if (rst)
			result_q.valid <= 1'b0;
		else
			result_q.valid <= done;
		if (done)
		begin
			result_q.tag <= tag_q;
			result_q.value <= want_rem ? rem : quo;
			result_q.cause <= dbz ? div_pkg::CAUSE_DBZ : div_pkg::CAUSE_NONE;
		end
	end

	assign result = result_q;

	// The queue must hold its head back while a divide is in flight
	accept_idle_a: assert property (@(posedge clk) disable iff (rst)
		uop.valid |-> !busy);

endmodule

// ==== div_opq.sv ====
// Divide operand queue

`timescale 1ns/1ps

module div_opq (
	input  logic              clk,
	input  logic              rst,
	input  div_pkg::div_uop_t uop_in,
	input  logic              busy,
	output div_pkg::div_uop_t uop,
	output logic              credit_ret
);

	div_pkg::div_uop_t mem [div_pkg::OPQ_DEPTH];
	logic [div_pkg::OPQ_PTR_W-1:0] wr_ptr;
	logic [div_pkg::OPQ_PTR_W-1:0] rd_ptr;
	logic [div_pkg::OPQ_CNT_W-1:0] count;
	logic push;
	logic pop;

	// Upstream only drives valid while it holds a credit
	assign push = uop_in.valid;
	// Head leaves only when something is waiting and the unit is free
	assign pop = (count != '0) && !busy;

	// Entry storage
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= uop_in;
	end

	// ========================================
	// Pointers and occupancy
	// ========================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap naturally over the power of two depth
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head is presented with valid replaced by the pop condition
	always_comb
	begin
		uop = mem[rd_ptr];
		uop.valid = pop;
	end

	// Each departure hands one credit back upstream
	assign credit_ret = pop;

	no_overflow_a: assert property (@(posedge clk) disable iff (rst)
		push |-> count < div_pkg::OPQ_DEPTH);

endmodule

// ==== div_top.sv ====
// Divide unit top level

`timescale 1ns/1ps

module div_top (
	input  logic                 clk,
	input  logic                 rst,
	input  div_pkg::div_uop_t    uop_in,
	output logic                 credit_ret,
	output div_pkg::div_result_t result
);

	// Head of queue to the unit
	div_pkg::div_uop_t uop;
	// Unit occupied, holds the queue head back
	logic busy;

	// ========================================
	// Operand queue
	// ========================================

	div_opq div_opq_inst (
		.clk        (clk),
		.rst        (rst),
		.uop_in     (uop_in),
		.busy       (busy),
		.uop        (uop),
		.credit_ret (credit_ret)
	);

	// ========================================
	// Divide unit
	// ========================================

	// One divide in flight at a time keeps results in issue order
	div_unit div_unit_inst (
		.clk    (clk),
		.rst    (rst),
		.uop    (uop),
		.busy   (busy),
		.result (result)
	);

endmodule

// ==== div_tb.sv ====
// Divide unit testbench

`timescale 1ns/1ps

module div_tb;

	localparam int N_TABLE = 20;
	localparam int N_RANDOM = 40;
	localparam int N_TOTAL = N_TABLE + N_RANDOM;
	// Worst case per op is DATA_W+4 cycles from pop to result, plus reset and drain slack
	localparam int TIMEOUT_CYC = N_TOTAL * (div_pkg::DATA_W + 4) + 200;

	// One directed case with its expected answer
	typedef struct packed {
		div_pkg::div_op_e          op;
		logic                      use_imm;
		logic [div_pkg::DATA_W-1:0] a;
		logic [div_pkg::DATA_W-1:0] b;
		logic [div_pkg::IMM_W-1:0]  imm;
		logic [div_pkg::DATA_W-1:0] value;
		div_pkg::cause_e           cause;
	} vec_t;

	logic clk;
	logic rst;
	div_pkg::div_uop_t uop_in;
	logic credit_ret;
	div_pkg::div_result_t result;

	vec_t tbl [N_TABLE];
	div_pkg::div_result_t exp_q [$];
	string name_q [$];
	logic [31:0] lfsr;
	int credits;
	int issued;
	int checked;
	int passed;
	int failed;
	int errors;
	int cycles;

	div_top div_top_inst (
		.clk        (clk),
		.rst        (rst),
		.uop_in     (uop_in),
		.credit_ret (credit_ret),
		.result     (result)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	function automatic vec_t make_row(input div_pkg::div_op_e op, input logic use_imm,
		input logic [31:0] a, input logic [31:0] b, input logic [15:0] imm,
		input logic [31:0] value, input logic dbz);
		vec_t v;
		v.op = op;
		v.use_imm = use_imm;
		v.a = a;
		v.b = b;
		v.imm = imm;
		v.value = value;
		v.cause = dbz ? div_pkg::CAUSE_DBZ : div_pkg::CAUSE_NONE;
		return v;
	endfunction

	// Expected values worked out by hand from truncating division rules
	task automatic load_table();
		tbl[0]  = make_row(div_pkg::DOP_DIV, 1'b0, 'h00000064, 'h00000007, 'h0000, 'h0000000E, 1'b0);
		tbl[1]  = make_row(div_pkg::DOP_DIV, 1'b0, 'hFFFFFF9C, 'h00000007, 'h0000, 'hFFFFFFF2, 1'b0);
		tbl[2]  = make_row(div_pkg::DOP_DIV, 1'b0, 'h00000064, 'hFFFFFFF9, 'h0000, 'hFFFFFFF2, 1'b0);
		tbl[3]  = make_row(div_pkg::DOP_DIV, 1'b0, 'hFFFFFF9C, 'hFFFFFFF9, 'h0000, 'h0000000E, 1'b0);
		tbl[4]  = make_row(div_pkg::DOP_DIVU, 1'b0, 'hFFFFFF9C, 'h00000007, 'h0000, 'h24924916, 1'b0);
		// Most negative over minus one wraps
		tbl[5]  = make_row(div_pkg::DOP_DIV, 1'b0, 'h80000000, 'hFFFFFFFF, 'h0000, 'h80000000, 1'b0);
		tbl[6]  = make_row(div_pkg::DOP_REM, 1'b0, 'h80000000, 'hFFFFFFFF, 'h0000, 'h00000000, 1'b0);
		// Remainder sign follows the dividend
		tbl[7]  = make_row(div_pkg::DOP_REM, 1'b0, 'h00000064, 'h00000007, 'h0000, 'h00000002, 1'b0);
		tbl[8]  = make_row(div_pkg::DOP_REM, 1'b0, 'hFFFFFF9C, 'h00000007, 'h0000, 'hFFFFFFFE, 1'b0);
		tbl[9]  = make_row(div_pkg::DOP_REM, 1'b0, 'h00000064, 'hFFFFFFF9, 'h0000, 'h00000002, 1'b0);
		tbl[10] = make_row(div_pkg::DOP_REM, 1'b0, 'hFFFFFF9C, 'hFFFFFFF9, 'h0000, 'hFFFFFFFE, 1'b0);
		tbl[11] = make_row(div_pkg::DOP_REMU, 1'b0, 'hFFFFFF9C, 'h00000007, 'h0000, 'h00000002, 1'b0);
		// Immediate divisors where b must be ignored
		tbl[12] = make_row(div_pkg::DOP_DIV, 1'b1, 'h000003E8, 'h00000003, 'hFFF6, 'hFFFFFF9C, 1'b0);
		tbl[13] = make_row(div_pkg::DOP_REM, 1'b1, 'h000003E9, 'h00000003, 'hFFF6, 'h00000001, 1'b0);
		tbl[14] = make_row(div_pkg::DOP_DIV, 1'b1, 'hFFFFFC18, 'h00000003, 'h0019, 'hFFFFFFD8, 1'b0);
		tbl[15] = make_row(div_pkg::DOP_DIVU, 1'b1, 'hFFFFFFFF, 'h00000003, 'hFFFF, 'h00000001, 1'b0);
		// Zero divisors
		tbl[16] = make_row(div_pkg::DOP_DIV, 1'b0, 'h00003039, 'h00000000, 'h0000, 'hFFFFFFFF, 1'b1);
		tbl[17] = make_row(div_pkg::DOP_REMU, 1'b0, 'hDEADBEEF, 'h00000000, 'h0000, 'hDEADBEEF, 1'b1);
		tbl[18] = make_row(div_pkg::DOP_REM, 1'b1, 'h80000000, 'h00000005, 'h0000, 'h80000000, 1'b1);
		tbl[19] = make_row(div_pkg::DOP_DIVU, 1'b0, 'hFFFFFFFF, 'h00000010, 'h0000, 'h0FFFFFFF, 1'b0);
	endtask

	// Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Fills op and operands, with some zero and some small divisors
	task automatic random_uop(inout div_pkg::div_uop_t u);
		logic [31:0] bits;
		logic [2:0] sel;
		take_bits(2, bits);
		u.op = div_pkg::div_op_e'(bits[1:0]);
		take_bits(2, bits);
		u.use_imm = (bits[1:0] == 2'd0);
		take_bits(32, bits);
		u.a = bits;
		take_bits(3, bits);
		sel = bits[2:0];
		take_bits(32, bits);
		if (sel == 3'd0)
			u.b = '0;
		else if (sel < 3'd3)
			u.b = {{24{bits[7]}}, bits[7:0]};
		else
			u.b = bits;
		take_bits(16, bits);
		u.imm = bits[15:0];
	endtask

	// ========================================
	// Reference model
	// ========================================

	function automatic div_pkg::div_result_t model_divide(input div_pkg::div_uop_t u);
		logic [div_pkg::DATA_W-1:0] d;
		logic signed [div_pkg::DATA_W-1:0] sa;
		logic signed [div_pkg::DATA_W-1:0] sd;
		logic [div_pkg::DATA_W-1:0] q;
		logic [div_pkg::DATA_W-1:0] r;
		logic is_signed;
		div_pkg::div_result_t e;
		// A 16-bit immediate widens as a signed number
		sd = u.use_imm ? 32'($signed(u.imm)) : $signed(u.b);
		d = sd;
		sa = u.a;
		is_signed = (u.op == div_pkg::DOP_DIV) || (u.op == div_pkg::DOP_REM);
		e = '0;
		e.valid = 1'b1;
		e.tag = u.tag;
		e.cause = div_pkg::CAUSE_NONE;
		if (d == '0)
		begin
			q = '1;
			r = u.a;
			e.cause = div_pkg::CAUSE_DBZ;
		end
		else if (is_signed && u.a == 32'h80000000 && d == 32'hFFFFFFFF)
		begin
			q = u.a;
			r = '0;
		end
		else if (is_signed)
		begin
			q = sa / sd;
			r = sa % sd;
		end
		else
		begin
			q = u.a / d;
			r = u.a % d;
		end
		e.value = (u.op == div_pkg::DOP_REM || u.op == div_pkg::DOP_REMU) ? r : q;
		return e;
	endfunction

	// Builds op number idx, from the table first and then random
	task automatic prepare_op(input int idx, output div_pkg::div_uop_t u,
		output div_pkg::div_result_t e, output string nm);
		u = '0;
		u.valid = 1'b1;
		u.tag = div_pkg::TAG_W'(idx);
		if (idx < N_TABLE)
		begin
			u.op = tbl[idx].op;
			u.use_imm = tbl[idx].use_imm;
			u.a = tbl[idx].a;
			u.b = tbl[idx].b;
			u.imm = tbl[idx].imm;
			e = '0;
			e.valid = 1'b1;
			e.tag = u.tag;
			e.value = tbl[idx].value;
			e.cause = tbl[idx].cause;
			nm = $sformatf("table %0d", idx);
		end
		else
		begin
			random_uop(u);
			e = model_divide(u);
			nm = $sformatf("random %0d", idx - N_TABLE);
		end
	endtask

	task automatic count_credit();
		if (credit_ret)
		begin
			credits++;
			if (credits > div_pkg::OPQ_DEPTH)
			begin
				$display("more credits returned than ops were issued");
				errors++;
			end
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		uop_in <= '0;
		count_credit();
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial
	begin
		div_pkg::div_uop_t u;
		div_pkg::div_result_t e;
		string nm;
		int quiet_bad;
		rst = 1'b1;
		uop_in = '0;
		credits = div_pkg::OPQ_DEPTH;
		lfsr = 32'h2d70a95c;
		issued = 0;
		quiet_bad = 0;
		load_table();
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// Nothing may come out before the first op goes in
		repeat (4)
		begin
			@(posedge clk);
			if (result.valid || credit_ret)
				quiet_bad++;
		end
		if (quiet_bad != 0)
		begin
			$display("result or credit pulse seen after reset before any op was sent");
			errors++;
			failed++;
		end
		else
		begin
			$display("reset quiet: ok");
			passed++;
		end

		// Issue whenever a credit is held, so the first ops form a full burst
		while (issued < N_TOTAL)
		begin
			@(posedge clk);
			count_credit();
			if (credits > 0)
			begin
				prepare_op(issued, u, e, nm);
				exp_q.push_back(e);
				name_q.push_back(nm);
				uop_in <= u;
				credits--;
				issued++;
			end
			else
				uop_in <= '0;
		end

		while (checked < N_TOTAL)
			idle_cycle();
		// Extra cycles to catch stray result pulses
		repeat (div_pkg::DATA_W + 8)
			idle_cycle();

		if (credits != div_pkg::OPQ_DEPTH || exp_q.size() != 0)
		begin
			$display("credits back %0d of %0d, results missing %0d",
				credits, div_pkg::OPQ_DEPTH, exp_q.size());
			errors++;
			failed++;
		end
		else
		begin
			$display("credit return: ok");
			passed++;
		end

		$display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// ========================================
	// Result checker and timeout
	// ========================================

	always @(posedge clk)
	begin : check_result
		div_pkg::div_result_t exp;
		string nm;
		logic ok;
		if (!rst && result.valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("extra result with tag %0d while no op was outstanding", result.tag);
				errors++;
			end
			else
			begin
				exp = exp_q.pop_front();
				nm = name_q.pop_front();
				ok = 1'b1;
				if (result.tag != exp.tag)
				begin
					$display("MISMATCH %s tag expected %0d actual %0d", nm, exp.tag, result.tag);
					ok = 1'b0;
				end
				if (result.value != exp.value)
				begin
					$display("MISMATCH %s value expected %h actual %h", nm, exp.value, result.value);
					ok = 1'b0;
				end
				if (result.cause != exp.cause)
				begin
					$display("MISMATCH %s cause expected %0d actual %0d", nm, exp.cause, result.cause);
					ok = 1'b0;
				end
				if (ok)
				begin
					$display("%s: ok", nm);
					passed++;
				end
				else
				begin
					$display("%s: failed", nm);
					failed++;
					errors++;
				end
				checked++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYC)
		begin
			$display("timeout after %0d cycles, %0d results still outstanding",
				cycles, N_TOTAL - checked);
			$display("test failed");
			$finish;
		end
	end

endmodule

// ==== sources.f ====
div_pkg.sv
div_core.sv
div_unit.sv
div_opq.sv
div_top.sv
div_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := div_tb
FILELIST  := sources.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
